// File: include/avr_config.svh
`ifndef AVR_CONFIG_SVH
`define AVR_CONFIG_SVH

// Register file geometry
`define AVR_NUM_REGS    32
`define AVR_REG_ADDR_W  5
`define AVR_DATA_W      8
`define AVR_WORD_W      16

// SREG bit positions
`define AVR_SREG_C  0
`define AVR_SREG_Z  1
`define AVR_SREG_N  2
`define AVR_SREG_V  3
`define AVR_SREG_S  4
`define AVR_SREG_H  5

`endif

// File: logic/avr_pkg.sv
`default_nettype none

package avr_pkg;

`include "avr_config.svh"

	typedef enum logic [4:0] {
		OP_NONE = 5'd0,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_SUBI,
		OP_ANDI,
		OP_ORI,
		OP_LDI,
		OP_INC,
		OP_DEC,
		OP_COM,
		OP_NEG,
		OP_LSR,
		OP_ROR,
		OP_SWAP,
		OP_ADIW,
		OP_SBIW,
		OP_MUL
	} alu_op_e;

	typedef struct packed {
		logic                       valid;
		alu_op_e                    op;
		logic                       is_word;    // ADIW, SBIW, MUL
		logic [`AVR_REG_ADDR_W-1:0] rd;
		logic [`AVR_REG_ADDR_W-1:0] rr;
		logic [`AVR_DATA_W-1:0]     imm;
	} decoded_t;

	typedef struct packed {
		logic [`AVR_WORD_W-1:0] result;
		logic [`AVR_DATA_W-1:0] sreg_next;
	} alu_out_t;

	typedef struct packed {
		logic                       we;
		logic                       pair;
		logic [`AVR_REG_ADDR_W-1:0] addr;
		logic [`AVR_WORD_W-1:0]     data;
	} reg_wr_t;

	typedef struct packed {
		logic                       valid;
		logic                       pair;
		logic [`AVR_REG_ADDR_W-1:0] addr;
		logic [`AVR_WORD_W-1:0]     data;
	} wb_t;

endpackage

`default_nettype wire

// File: logic/op_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module op_decoder (
	input  wire              ALU_CLK,
	input  wire              hclk,
	input  wire              i_valid,
	input  wire [15:0]       i_opcode,
	output avr_pkg::decoded_t o_dec
);

	avr_pkg::decoded_t dec_next;

	always_comb
	begin
		dec_next = '0;
		dec_next.op = avr_pkg::OP_NONE;
		dec_next.rd = i_opcode[8:4];
		dec_next.rr = {i_opcode[9], i_opcode[3:0]};
		dec_next.imm = {i_opcode[11:8], i_opcode[3:0]};
		case (i_opcode[15:12])
			4'h0:
			begin
				if (i_opcode[11:10] == 2'b11)
					dec_next.op = avr_pkg::OP_ADD;
				else if (i_opcode[11:10] == 2'b10)
					dec_next.op = avr_pkg::OP_SBC;
			end
			4'h1:
			begin
				if (i_opcode[11:10] == 2'b11)
					dec_next.op = avr_pkg::OP_ADC;
				else if (i_opcode[11:10] == 2'b10)
					dec_next.op = avr_pkg::OP_SUB;
			end
			4'h2:
			begin
				case (i_opcode[11:10])
					2'b00: dec_next.op = avr_pkg::OP_AND;
					2'b01: dec_next.op = avr_pkg::OP_EOR;
					2'b10: dec_next.op = avr_pkg::OP_OR;
					default: dec_next.op = avr_pkg::OP_NONE;  // MOV not kept
				endcase
			end
			4'h5, 4'h6, 4'h7, 4'hE:
			begin
				dec_next.rd = {1'b1, i_opcode[7:4]};  // Upper half only
				case (i_opcode[15:12])
					4'h5: dec_next.op = avr_pkg::OP_SUBI;
					4'h6: dec_next.op = avr_pkg::OP_ORI;
					4'h7: dec_next.op = avr_pkg::OP_ANDI;
					default: dec_next.op = avr_pkg::OP_LDI;
				endcase
			end
			4'h9:
			begin
				if (i_opcode[11:10] == 2'b11)
				begin
					dec_next.op = avr_pkg::OP_MUL;
					dec_next.is_word = 1'b1;
				end
				else if (i_opcode[11:9] == 3'b011)
				begin
					// ADIW/SBIW on r24, r26, r28, r30
					dec_next.op = i_opcode[8] ? avr_pkg::OP_SBIW : avr_pkg::OP_ADIW;
					dec_next.is_word = 1'b1;
					dec_next.rd = {2'b11, i_opcode[5:4], 1'b0};
					dec_next.imm = {2'b00, i_opcode[7:6], i_opcode[3:0]};
				end
				else if (i_opcode[11:9] == 3'b010)
				begin
					case (i_opcode[3:0])
						4'h0: dec_next.op = avr_pkg::OP_COM;
						4'h1: dec_next.op = avr_pkg::OP_NEG;
						4'h2: dec_next.op = avr_pkg::OP_SWAP;
						4'h3: dec_next.op = avr_pkg::OP_INC;
						4'h6: dec_next.op = avr_pkg::OP_LSR;
						4'h7: dec_next.op = avr_pkg::OP_ROR;
						4'hA: dec_next.op = avr_pkg::OP_DEC;
						default: dec_next.op = avr_pkg::OP_NONE;
					endcase
				end
			end
			default: dec_next.op = avr_pkg::OP_NONE;
		endcase
		dec_next.valid = i_valid && (dec_next.op != avr_pkg::OP_NONE);
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			o_dec <= '0;
		else
			o_dec <= dec_next;
	end

	// A strobed ADIW/SBIW lands next cycle as an aligned pair op
	assert property (@(posedge ALU_CLK) disable iff (hclk)
		i_valid && (i_opcode[15:9] == 7'b1001011)
			|=> o_dec.valid && o_dec.is_word && !o_dec.rd[0]);

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "avr_config.svh"

module reg_file (
	input  wire                        ALU_CLK,
	input  wire                        hclk,
	input  wire [`AVR_REG_ADDR_W-1:0]  i_rd_addr,
	input  wire [`AVR_REG_ADDR_W-1:0]  i_rr_addr,
	input  avr_pkg::reg_wr_t           i_wr,
	output logic [`AVR_DATA_W-1:0]     o_rd_data,
	output logic [`AVR_DATA_W-1:0]     o_rr_data,
	output logic [`AVR_WORD_W-1:0]     o_pair_data
);

	logic [`AVR_DATA_W-1:0] regs [0:`AVR_NUM_REGS-1];

	assign o_rd_data = regs[i_rd_addr];
	assign o_rr_data = regs[i_rr_addr];
	assign o_pair_data = {regs[{i_rd_addr[4:1], 1'b1}], regs[{i_rd_addr[4:1], 1'b0}]};

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			for (int i = 0; i < `AVR_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_wr.we)
		begin
			if (i_wr.pair)
			begin
				regs[{i_wr.addr[4:1], 1'b0}] <= i_wr.data[7:0];
				regs[{i_wr.addr[4:1], 1'b1}] <= i_wr.data[15:8];  // High byte
			end
			else
				regs[i_wr.addr] <= i_wr.data[7:0];
		end
	end

	// Pair writes come from the merge stage already aligned
	assert property (@(posedge ALU_CLK) disable iff (hclk)
		i_wr.we && i_wr.pair |-> !i_wr.addr[0]);

endmodule

`default_nettype wire

// File: logic/byte_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "avr_config.svh"

module byte_alu (
	input  avr_pkg::decoded_t          i_dec,
	input  wire [`AVR_DATA_W-1:0]      i_rd_data,
	input  wire [`AVR_DATA_W-1:0]      i_rr_data,
	input  wire [`AVR_DATA_W-1:0]      i_sreg,
	output avr_pkg::alu_out_t          o_out
);

	logic [`AVR_DATA_W-1:0] op_a;
	logic [`AVR_DATA_W-1:0] op_b;
	logic                   cin;
	logic                   is_sub;
	logic [`AVR_DATA_W:0]   arith;
	logic [`AVR_DATA_W-1:0] r;
	logic                   h_arith;
	logic                   v_arith;
	logic [`AVR_DATA_W-1:0] res;
	logic [`AVR_DATA_W-1:0] flags;
	logic                   set_nzs;
	logic                   z_keep;

	always_comb
	begin
		op_a = i_rd_data;
		op_b = i_rr_data;
		cin = 1'b0;
		is_sub = 1'b0;
		case (i_dec.op)
			avr_pkg::OP_ADC: cin = i_sreg[`AVR_SREG_C];
			avr_pkg::OP_SUB: is_sub = 1'b1;
			avr_pkg::OP_SBC:
			begin
				is_sub = 1'b1;
				cin = i_sreg[`AVR_SREG_C];
			end
			avr_pkg::OP_SUBI, avr_pkg::OP_ANDI, avr_pkg::OP_ORI:
			begin
				is_sub = (i_dec.op == avr_pkg::OP_SUBI);
				op_b = i_dec.imm;
			end
			avr_pkg::OP_NEG:
			begin
				// 0 - Rd through the subtractor
				op_a = '0;
				op_b = i_rd_data;
				is_sub = 1'b1;
			end
			default: cin = 1'b0;
		endcase
	end

	assign arith = is_sub ? {1'b0, op_a} - {1'b0, op_b} - 9'(cin)
		: {1'b0, op_a} + {1'b0, op_b} + 9'(cin);
	assign r = arith[7:0];

	// Carries out of bit 3 and bit 7
	assign h_arith = is_sub
		? ((~op_a[3] & op_b[3]) | (op_b[3] & r[3]) | (r[3] & ~op_a[3]))
		: ((op_a[3] & op_b[3]) | (op_b[3] & ~r[3]) | (~r[3] & op_a[3]));
	assign v_arith = is_sub
		? ((op_a[7] & ~op_b[7] & ~r[7]) | (~op_a[7] & op_b[7] & r[7]))
		: ((op_a[7] & op_b[7] & ~r[7]) | (~op_a[7] & ~op_b[7] & r[7]));

	always_comb
	begin
		res = i_rd_data;
		flags = i_sreg;
		set_nzs = 1'b1;
		z_keep = 1'b1;
		case (i_dec.op)
			avr_pkg::OP_ADD, avr_pkg::OP_ADC, avr_pkg::OP_SUB, avr_pkg::OP_SBC,
			avr_pkg::OP_SUBI, avr_pkg::OP_NEG:
			begin
				res = r;
				flags[`AVR_SREG_C] = arith[8];  // Borrow on subtract
				flags[`AVR_SREG_H] = h_arith;
				flags[`AVR_SREG_V] = v_arith;
				if (i_dec.op == avr_pkg::OP_SBC)
					z_keep = i_sreg[`AVR_SREG_Z];  // Sticky Z across chains
			end
			avr_pkg::OP_AND, avr_pkg::OP_ANDI:
			begin
				res = i_rd_data & op_b;
				flags[`AVR_SREG_V] = 1'b0;
			end
			avr_pkg::OP_OR, avr_pkg::OP_ORI:
			begin
				res = i_rd_data | op_b;
				flags[`AVR_SREG_V] = 1'b0;
			end
			avr_pkg::OP_EOR:
			begin
				res = i_rd_data ^ op_b;
				flags[`AVR_SREG_V] = 1'b0;
			end
			avr_pkg::OP_INC:
			begin
				res = i_rd_data + 8'd1;
				flags[`AVR_SREG_V] = (res == 8'h80);
			end
			avr_pkg::OP_DEC:
			begin
				res = i_rd_data - 8'd1;
				flags[`AVR_SREG_V] = (res == 8'h7F);
			end
			avr_pkg::OP_COM:
			begin
				res = ~i_rd_data;
				flags[`AVR_SREG_V] = 1'b0;
				flags[`AVR_SREG_C] = 1'b1;
			end
			avr_pkg::OP_LSR, avr_pkg::OP_ROR:
			begin
				res = {(i_dec.op == avr_pkg::OP_ROR) & i_sreg[`AVR_SREG_C], i_rd_data[7:1]};
				flags[`AVR_SREG_C] = i_rd_data[0];
				flags[`AVR_SREG_V] = res[7] ^ i_rd_data[0];  // N xor C
			end
			avr_pkg::OP_LDI:
			begin
				res = i_dec.imm;
				set_nzs = 1'b0;
			end
			avr_pkg::OP_SWAP:
			begin
				res = {i_rd_data[3:0], i_rd_data[7:4]};
				set_nzs = 1'b0;
			end
			default: set_nzs = 1'b0;
		endcase
		if (set_nzs)
		begin
			flags[`AVR_SREG_N] = res[7];
			flags[`AVR_SREG_Z] = (res == '0) & z_keep;
			flags[`AVR_SREG_S] = res[7] ^ flags[`AVR_SREG_V];
		end
	end

	assign o_out = '{result: {{(`AVR_WORD_W-`AVR_DATA_W){1'b0}}, res}, sreg_next: flags};

endmodule

`default_nettype wire

// File: logic/word_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "avr_config.svh"

module word_alu (
	input  avr_pkg::decoded_t          i_dec,
	input  wire [`AVR_WORD_W-1:0]      i_pair_data,
	input  wire [`AVR_DATA_W-1:0]      i_rd_data,
	input  wire [`AVR_DATA_W-1:0]      i_rr_data,
	input  wire [`AVR_DATA_W-1:0]      i_sreg,
	output avr_pkg::alu_out_t          o_out
);

	logic [`AVR_WORD_W-1:0] res;
	logic [`AVR_DATA_W-1:0] flags;
	logic                   hi7;

	assign hi7 = i_pair_data[15];  // Rdh bit 7 before the op

	always_comb
	begin
		res = i_pair_data;
		flags = i_sreg;
		case (i_dec.op)
			avr_pkg::OP_ADIW, avr_pkg::OP_SBIW:
			begin
				if (i_dec.op == avr_pkg::OP_ADIW)
				begin
					res = i_pair_data + {8'h00, i_dec.imm};
					flags[`AVR_SREG_V] = ~hi7 & res[15];
					flags[`AVR_SREG_C] = hi7 & ~res[15];
				end
				else
				begin
					res = i_pair_data - {8'h00, i_dec.imm};
					flags[`AVR_SREG_V] = hi7 & ~res[15];
					flags[`AVR_SREG_C] = ~hi7 & res[15];
				end
				flags[`AVR_SREG_N] = res[15];
				flags[`AVR_SREG_Z] = (res == '0);
				flags[`AVR_SREG_S] = res[15] ^ flags[`AVR_SREG_V];
			end
			avr_pkg::OP_MUL:
			begin
				res = 16'(i_rd_data) * 16'(i_rr_data);  // Unsigned only
				flags[`AVR_SREG_C] = res[15];
				flags[`AVR_SREG_Z] = (res == '0);
			end
			default: res = i_pair_data;
		endcase
	end

	assign o_out = '{result: res, sreg_next: flags};

endmodule

`default_nettype wire

// File: logic/result_merge.sv
`timescale 1ns/1ns
`default_nettype none

`include "avr_config.svh"

module result_merge (
	input  wire                        ALU_CLK,
	input  wire                        hclk,
	input  avr_pkg::decoded_t          i_dec,
	input  avr_pkg::alu_out_t          i_byte_out,
	input  avr_pkg::alu_out_t          i_word_out,
	output avr_pkg::reg_wr_t           o_wr,
	output logic [`AVR_DATA_W-1:0]     o_sreg,
	output avr_pkg::wb_t               o_wb
);

	avr_pkg::alu_out_t sel;

	assign sel = i_dec.is_word ? i_word_out : i_byte_out;

	always_comb
	begin
		o_wr.we = i_dec.valid;
		o_wr.pair = i_dec.is_word;
		// MUL always lands in r1:r0
		o_wr.addr = (i_dec.op == avr_pkg::OP_MUL) ? '0 : i_dec.rd;
		o_wr.data = sel.result;
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			o_sreg <= '0;
			o_wb <= '0;
		end
		else
		begin
			if (i_dec.valid)
				o_sreg <= sel.sreg_next;
			o_wb.valid <= o_wr.we;
			o_wb.pair <= o_wr.pair;
			o_wb.addr <= o_wr.addr;
			o_wb.data <= o_wr.data;
		end
	end

	// No report without a decoded record the cycle before
	assert property (@(posedge ALU_CLK) disable iff (hclk)
		!i_dec.valid |=> !o_wb.valid);

endmodule

`default_nettype wire

// File: logic/avr_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module avr_exec_core (
	input  wire          ALU_CLK,
	input  wire          hclk,
	input  wire          i_valid,
	input  wire [15:0]   i_opcode,
	output avr_pkg::wb_t o_wb,
	output logic [7:0]   o_sreg
);

	avr_pkg::decoded_t dec;
	avr_pkg::alu_out_t byte_out;
	avr_pkg::alu_out_t word_out;
	avr_pkg::reg_wr_t  wr;
	logic [7:0]        rd_data;
	logic [7:0]        rr_data;
	logic [15:0]       pair_data;

	op_decoder op_decoder_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_valid(i_valid), .i_opcode(i_opcode), .o_dec(dec)
	);

	reg_file reg_file_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_rd_addr(dec.rd), .i_rr_addr(dec.rr), .i_wr(wr),
		.o_rd_data(rd_data), .o_rr_data(rr_data), .o_pair_data(pair_data)
	);

	byte_alu byte_alu_inst (
		.i_dec(dec), .i_rd_data(rd_data), .i_rr_data(rr_data), .i_sreg(o_sreg), .o_out(byte_out)
	);

	word_alu word_alu_inst (
		.i_dec(dec), .i_pair_data(pair_data), .i_rd_data(rd_data), .i_rr_data(rr_data),
		.i_sreg(o_sreg), .o_out(word_out)
	);

	result_merge result_merge_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_dec(dec), .i_byte_out(byte_out),
		.i_word_out(word_out), .o_wr(wr), .o_sreg(o_sreg), .o_wb(o_wb)
	);

endmodule

`default_nettype wire

// File: bench/avr_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "avr_config.svh"

module avr_exec_tb;

	typedef struct packed {
		logic         has_wb;
		avr_pkg::wb_t wb;
		logic [7:0]   sreg;
	} ref_t;

	typedef struct packed {
		avr_pkg::wb_t wb;
		logic [7:0]   sreg;
		logic [31:0]  cyc;  // Edge on which the strobe was driven
	} expect_t;

	localparam logic [5:0] hi_add = 6'b000011;
	localparam logic [5:0] hi_sbc = 6'b000010;
	localparam logic [5:0] hi_adc = 6'b000111;
	localparam logic [5:0] hi_sub = 6'b000110;
	localparam logic [5:0] hi_and = 6'b001000;
	localparam logic [5:0] hi_eor = 6'b001001;
	localparam logic [5:0] hi_or  = 6'b001010;
	localparam logic [5:0] hi_mul = 6'b100111;
	localparam int wb_timeout = 16;
	localparam int drain_limit = 200;

	logic         ALU_CLK;
	logic         hclk;
	logic         i_valid;
	logic [15:0]  i_opcode;
	avr_pkg::wb_t o_wb;
	logic [7:0]   o_sreg;

	logic [7:0]   model_regs [0:31];
	logic [7:0]   model_sreg;
	expect_t      exp_q [$];
	string        name_q [$];
	string        test_name;
	logic [31:0]  cyc;
	int           errors = 0;
	int           checks = 0;
	logic         timed_out = 1'b0;
	logic         stim_done = 1'b0;
	logic         check_done;

	avr_exec_core avr_exec_core_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_valid(i_valid), .i_opcode(i_opcode),
		.o_wb(o_wb), .o_sreg(o_sreg)
	);

	initial
	begin
		ALU_CLK = 1'b0;
		cyc = '0;
		forever
		begin
			#10;
			cyc = cyc + 32'd1;  // Counted ahead of the edge it names
			ALU_CLK = 1'b1;
			#10;
			ALU_CLK = 1'b0;
		end
	end

	// Nibble and signed-range view of an 8-bit add or subtract
	function automatic void arith8(input logic [7:0] a, input logic [7:0] b, input logic ci,
		input logic is_sub, output logic [7:0] r, output logic h, output logic v,
		output logic c);
		logic [8:0] full;
		logic [4:0] low;
		int         sv;
		if (is_sub)
		begin
			full = 9'(a) - 9'(b) - 9'(ci);
			low = 5'(a[3:0]) - 5'(b[3:0]) - 5'(ci);
			sv = int'($signed(a)) - int'($signed(b)) - int'(ci);
		end
		else
		begin
			full = 9'(a) + 9'(b) + 9'(ci);
			low = 5'(a[3:0]) + 5'(b[3:0]) + 5'(ci);
			sv = int'($signed(a)) + int'($signed(b)) + int'(ci);
		end
		r = full[7:0];
		c = full[8];
		h = low[4];
		v = (sv > 127) || (sv < -128);
	endfunction

	function automatic ref_t ref_exec(input logic [15:0] op);
		ref_t        rv;
		logic [4:0]  d;
		logic [4:0]  s;
		logic [4:0]  dh;
		logic [4:0]  dw;
		logic [4:0]  t;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  k;
		logic [7:0]  res;
		logic [7:0]  sr;
		logic [15:0] w;
		logic [15:0] wres;
		logic        h;
		logic        v;
		logic        c;
		logic        arith;
		logic        byte_wr;
		logic        word_wr;
		logic        nzs;
		logic        zkeep;
		d = op[8:4];
		s = {op[9], op[3:0]};
		dh = {1'b1, op[7:4]};
		dw = {2'b11, op[5:4], 1'b0};
		k = {op[11:8], op[3:0]};
		a = model_regs[d];
		b = model_regs[s];
		sr = model_sreg;
		t = d;
		res = '0;
		wres = '0;
		w = '0;
		{h, v, c} = '0;
		{arith, byte_wr, word_wr} = '0;
		nzs = 1'b1;
		zkeep = 1'b1;
		casez (op)
			16'b0000_11??_????_????: {arith, byte_wr} = 2'b11;
			16'b0001_11??_????_????: {arith, byte_wr} = 2'b11;
			16'b0001_10??_????_????: {arith, byte_wr} = 2'b11;
			16'b0000_10??_????_????:
			begin
				{arith, byte_wr} = 2'b11;
				zkeep = model_sreg[`AVR_SREG_Z];
			end
			16'b0010_00??_????_????: {byte_wr, res, sr[`AVR_SREG_V]} = {1'b1, a & b, 1'b0};
			16'b0010_01??_????_????: {byte_wr, res, sr[`AVR_SREG_V]} = {1'b1, a ^ b, 1'b0};
			16'b0010_10??_????_????: {byte_wr, res, sr[`AVR_SREG_V]} = {1'b1, a | b, 1'b0};
			16'b0101_????_????_????:
			begin
				t = dh;
				arith8(model_regs[dh], k, 1'b0, 1'b1, res, h, v, c);
				{arith, byte_wr} = 2'b11;
			end
			16'b0110_????_????_????:
			begin
				t = dh;
				{byte_wr, res, sr[`AVR_SREG_V]} = {1'b1, model_regs[dh] | k, 1'b0};
			end
			16'b0111_????_????_????:
			begin
				t = dh;
				{byte_wr, res, sr[`AVR_SREG_V]} = {1'b1, model_regs[dh] & k, 1'b0};
			end
			16'b1110_????_????_????: {t, byte_wr, res, nzs} = {dh, 1'b1, k, 1'b0};
			16'b1001_010?_????_0000: {byte_wr, res, sr[`AVR_SREG_V], sr[`AVR_SREG_C]} = {1'b1, ~a, 2'b01};
			16'b1001_010?_????_0001:
			begin
				arith8(8'h00, a, 1'b0, 1'b1, res, h, v, c);
				{arith, byte_wr} = 2'b11;
			end
			16'b1001_010?_????_0010: {byte_wr, res, nzs} = {1'b1, a[3:0], a[7:4], 1'b0};
			16'b1001_010?_????_0011:
			begin
				res = a + 8'd1;
				{byte_wr, sr[`AVR_SREG_V]} = {1'b1, res == 8'h80};
			end
			16'b1001_010?_????_1010:
			begin
				res = a - 8'd1;
				{byte_wr, sr[`AVR_SREG_V]} = {1'b1, res == 8'h7F};
			end
			16'b1001_010?_????_011?:
			begin
				res = {op[0] & model_sreg[`AVR_SREG_C], a[7:1]};  // ROR pulls in old C
				sr[`AVR_SREG_C] = a[0];
				sr[`AVR_SREG_V] = res[7] ^ a[0];
				byte_wr = 1'b1;
			end
			16'b1001_011?_????_????:
			begin
				t = dw;
				w = {model_regs[{dw[4:1], 1'b1}], model_regs[dw]};
				wres = op[8] ? w - {10'd0, op[7:6], op[3:0]} : w + {10'd0, op[7:6], op[3:0]};
				sr[`AVR_SREG_V] = op[8] ? (w[15] & ~wres[15]) : (~w[15] & wres[15]);
				sr[`AVR_SREG_C] = op[8] ? (~w[15] & wres[15]) : (w[15] & ~wres[15]);
				sr[`AVR_SREG_N] = wres[15];
				sr[`AVR_SREG_Z] = (wres == 16'h0000);
				sr[`AVR_SREG_S] = wres[15] ^ sr[`AVR_SREG_V];
				word_wr = 1'b1;
			end
			16'b1001_11??_????_????:
			begin
				t = 5'd0;
				wres = 16'(a) * 16'(b);
				sr[`AVR_SREG_C] = wres[15];
				sr[`AVR_SREG_Z] = (wres == 16'h0000);
				word_wr = 1'b1;
			end
			default: nzs = 1'b0;
		endcase
		// Register-register arithmetic still needs its operands
		if (arith && (op[15:13] == 3'b000))
			arith8(a, b, op[12] ? (op[10] & model_sreg[`AVR_SREG_C]) : ~op[10] & model_sreg[`AVR_SREG_C],
				~op[10], res, h, v, c);
		if (arith)
		begin
			sr[`AVR_SREG_C] = c;
			sr[`AVR_SREG_H] = h;
			sr[`AVR_SREG_V] = v;
		end
		if (byte_wr && nzs)
		begin
			sr[`AVR_SREG_N] = res[7];
			sr[`AVR_SREG_Z] = (res == 8'h00) && zkeep;
			sr[`AVR_SREG_S] = res[7] ^ sr[`AVR_SREG_V];
		end
		rv = '0;
		if (byte_wr)
		begin
			model_regs[t] = res;
			wres = {8'h00, res};
		end
		if (word_wr)
		begin
			model_regs[t] = wres[7:0];
			model_regs[{t[4:1], 1'b1}] = wres[15:8];
		end
		if (byte_wr || word_wr)
		begin
			rv.has_wb = 1'b1;
			rv.wb.valid = 1'b1;
			rv.wb.pair = word_wr;
			rv.wb.addr = t;
			rv.wb.data = wres;
		end
		model_sreg = sr;
		rv.sreg = sr;
		return rv;
	endfunction

	function automatic logic [15:0] two_reg_opcode(input logic [5:0] hi, input logic [4:0] d,
		input logic [4:0] s);
		return {hi, s[4], d, s[3:0]};
	endfunction

	function automatic logic [15:0] imm_opcode(input logic [3:0] hi, input logic [4:0] d,
		input logic [7:0] k);
		return {hi, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] single_opcode(input logic [4:0] d, input logic [3:0] sub);
		return {7'b1001010, d, sub};
	endfunction

	function automatic logic [15:0] pair_imm_opcode(input logic sub, input logic [1:0] p,
		input logic [5:0] k);
		return {7'b1001011, sub, k[5:4], p, k[3:0]};
	endfunction

	task automatic issue(input logic [15:0] op);
		ref_t    rv;
		expect_t e;
		@(posedge ALU_CLK);
		i_valid <= 1'b1;
		i_opcode <= op;
		rv = ref_exec(op);
		if (rv.has_wb)
		begin
			e.wb = rv.wb;
			e.sreg = rv.sreg;
			e.cyc = cyc;
			exp_q.push_back(e);
			name_q.push_back(test_name);
		end
	endtask

	task automatic idle();
		@(posedge ALU_CLK);
		i_valid <= 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		idle();
		while (exp_q.size() > 0 && n < drain_limit && !timed_out)
		begin
			@(posedge ALU_CLK);
			n++;
		end
		if (exp_q.size() > 0 && !timed_out)
		begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: writebacks for %s never arrived", test_name);
		end
	endtask

	task automatic load_reg(input logic [4:0] addr, input logic [7:0] val);
		if (addr >= 5'd16)
			issue(imm_opcode(4'hE, addr, val));
		else
		begin
			issue(two_reg_opcode(hi_eor, addr, addr));
			issue(imm_opcode(4'hE, 5'd31, val));
			issue(two_reg_opcode(hi_or, addr, 5'd31));
		end
	endtask

	task automatic load_pair(input logic [1:0] p, input logic [15:0] val);
		load_reg({2'b11, p, 1'b0}, val[7:0]);
		load_reg({2'b11, p, 1'b1}, val[15:8]);
	endtask

	// 16-bit subtract in r1:r0 minus r3:r2
	task automatic sbc_chain(input logic [15:0] x, input logic [15:0] y);
		load_reg(5'd0, x[7:0]);
		load_reg(5'd1, x[15:8]);
		load_reg(5'd2, y[7:0]);
		load_reg(5'd3, y[15:8]);
		issue(two_reg_opcode(hi_sub, 5'd0, 5'd2));
		issue(two_reg_opcode(hi_sbc, 5'd1, 5'd3));
	endtask

	initial
	begin : compare_proc
		expect_t     e;
		string       nm;
		int          waited;
		waited = 0;
		check_done = 1'b0;
		while ((!stim_done || exp_q.size() > 0) && !timed_out)
		begin
			@(negedge ALU_CLK);
			if (o_wb.valid)
			begin
				checks++;
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("error: writeback to r%0d with no instruction pending", o_wb.addr);
				end
				else
				begin
					e = exp_q.pop_front();
					nm = name_q.pop_front();
					waited = 0;
					if (o_wb !== e.wb)
					begin
						errors++;
						$display("mismatch %s wb expected %h actual %h", nm, e.wb, o_wb);
					end
					if (o_sreg !== e.sreg)
					begin
						errors++;
						$display("mismatch %s sreg expected %h actual %h", nm, e.sreg, o_sreg);
					end
					if (cyc - e.cyc != 32'd2)
					begin
						errors++;
						$display("mismatch %s latency expected 2 actual %0d", nm, cyc - e.cyc);
					end
				end
			end
			else if (exp_q.size() > 0)
			begin
				waited++;
				if (waited > wb_timeout)
				begin
					errors++;
					timed_out = 1'b1;
					$display("timeout: no writeback seen for %s", name_q[0]);
				end
			end
		end
		check_done = 1'b1;
	end

	initial
	begin : stim_proc
		logic [4:0]  d;
		logic [4:0]  s;
		logic [4:0]  dh;
		logic [7:0]  k;
		logic [5:0]  hi;
		int          sel;
		int          n;
		i_valid = 1'b0;
		i_opcode = 16'h0000;
		hclk = 1'b1;
		model_sreg = 8'h00;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 8'h00;
		void'($urandom(88317));
		repeat (2) @(posedge ALU_CLK);
		hclk <= 1'b0;

		test_name = "reset";
		repeat (3)
		begin
			@(negedge ALU_CLK);
			checks++;
			if (o_sreg !== 8'h00)
			begin
				errors++;
				$display("mismatch %s sreg expected 00 actual %h", test_name, o_sreg);
			end
			if (o_wb.valid !== 1'b0)
			begin
				errors++;
				$display("error: o_wb.valid went high during reset idle");
			end
		end
		test_name = "ldi";
		for (int i = 16; i < 32; i++)
			load_reg(5'(i), 8'($urandom()));
		drain();

		test_name = "add_sub";
		for (int i = 0; i < 16; i++)
			load_reg(5'(i), 8'($urandom()));
		for (int i = 0; i < 40; i++)
		begin
			sel = int'($urandom_range(0, 3));
			hi = (sel == 0) ? hi_add : (sel == 1) ? hi_adc : (sel == 2) ? hi_sub : hi_sbc;
			issue(two_reg_opcode(hi, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31))));
		end
		test_name = "sbc_chain";
		sbc_chain(16'h1234, 16'h1234);  // Z survives
		sbc_chain(16'h1235, 16'h1234);  // Low byte clears Z
		sbc_chain(16'h1200, 16'h1300);
		sbc_chain(16'h0000, 16'h0001);
		drain();

		test_name = "logic_single";
		load_reg(5'd20, 8'h7F);
		issue(single_opcode(5'd20, 4'h3));
		load_reg(5'd21, 8'h80);
		issue(single_opcode(5'd21, 4'hA));
		issue(single_opcode(5'd21, 4'h1));
		for (int i = 0; i < 60; i++)
		begin
			sel = int'($urandom_range(0, 12));
			d = 5'($urandom_range(0, 31));
			s = 5'($urandom_range(0, 31));
			dh = 5'($urandom_range(16, 31));
			k = 8'($urandom());
			case (sel)
				0: issue(two_reg_opcode(hi_and, d, s));
				1: issue(two_reg_opcode(hi_or, d, s));
				2: issue(two_reg_opcode(hi_eor, d, s));
				3: issue(imm_opcode(4'h7, dh, k));
				4: issue(imm_opcode(4'h6, dh, k));
				5: issue(imm_opcode(4'h5, dh, k));
				6: issue(single_opcode(d, 4'h0));
				7: issue(single_opcode(d, 4'h1));
				8: issue(single_opcode(d, 4'h3));
				9: issue(single_opcode(d, 4'hA));
				10: issue(single_opcode(d, 4'h6));
				11: issue(single_opcode(d, 4'h7));
				default: issue(single_opcode(d, 4'h2));
			endcase
		end
		drain();

		test_name = "word_ops";
		load_pair(2'd0, 16'h7FFF);
		issue(pair_imm_opcode(1'b0, 2'd0, 6'd1));
		load_pair(2'd1, 16'hFFFF);
		issue(pair_imm_opcode(1'b0, 2'd1, 6'd1));
		load_pair(2'd2, 16'h0000);
		issue(pair_imm_opcode(1'b1, 2'd2, 6'd1));
		load_pair(2'd3, 16'h8000);
		issue(pair_imm_opcode(1'b1, 2'd3, 6'd1));
		for (int p = 0; p < 4; p++)
		begin
			load_pair(2'(p), 16'($urandom()));
			issue(pair_imm_opcode(1'b0, 2'(p), 6'($urandom())));
			issue(pair_imm_opcode(1'b1, 2'(p), 6'($urandom())));
		end
		load_reg(5'd16, 8'hFF);
		load_reg(5'd17, 8'hFF);
		issue(two_reg_opcode(hi_mul, 5'd16, 5'd17));
		load_reg(5'd18, 8'h00);
		issue(two_reg_opcode(hi_mul, 5'd18, 5'd17));
		for (int i = 0; i < 6; i++)
			issue(two_reg_opcode(hi_mul, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31))));
		drain();

		test_name = "stream";
		for (int i = 0; i < 30; i++)
		begin
			sel = int'($urandom_range(0, 6));
			d = 5'($urandom_range(16, 19));
			s = 5'($urandom_range(16, 19));
			case (sel)
				0: issue(two_reg_opcode(hi_add, d, s));
				1: issue(two_reg_opcode(hi_sbc, d, s));
				2: issue(two_reg_opcode(hi_adc, d, s));
				3: issue(single_opcode(d, 4'h3));
				4: issue(two_reg_opcode(hi_mul, d, s));
				5: issue(two_reg_opcode(hi_add, d, 5'($urandom_range(0, 1))));
				default: issue(imm_opcode(4'hE, d, 8'($urandom())));
			endcase
		end
		drain();

		test_name = "unsupported";
		issue(16'h0000);
		issue(16'h2C12);
		issue(16'h9408);
		issue(16'hF000);
		issue(16'h8000);
		idle();
		repeat (4)
		begin
			@(negedge ALU_CLK);
			checks++;
			if (o_wb.valid !== 1'b0)
			begin
				errors++;
				$display("error: unsupported opcode produced a writeback");
			end
			if (o_sreg !== model_sreg)
			begin
				errors++;
				$display("mismatch %s sreg expected %h actual %h", test_name, model_sreg, o_sreg);
			end
		end
		for (int i = 0; i < 32; i += 4)
			issue(two_reg_opcode(hi_or, 5'(i), 5'(i)));  // Reads back unchanged contents
		drain();

		stim_done = 1'b1;
		n = 0;
		while (!check_done && n < 50)
		begin
			@(posedge ALU_CLK);
			n++;
		end
		if (!check_done)
		begin
			errors++;
			$display("timeout: compare process did not finish");
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
logic/avr_pkg.sv
logic/op_decoder.sv
logic/reg_file.sv
logic/byte_alu.sv
logic/word_alu.sv
logic/result_merge.sv
logic/avr_exec_core.sv
bench/avr_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module avr_exec_tb \
	-Mdir obj_dir -o avr_exec_sim
./obj_dir/avr_exec_sim > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
exit 1
